// ==== nic_settings.svh ====
// NIC transmit settings
// Bus widths, BAR0 register map and read chunk size
`ifndef NIC_SETTINGS_SVH
`define NIC_SETTINGS_SVH

// Local-link and address widths
`define NIC_DATA_W       64
`define NIC_REM_W        8
`define NIC_ADDR_W       64
`define NIC_QW_W         32

// Read chunking, 16 quadwords is 128 bytes
`define NIC_CHUNK_QW     16
`define NIC_CHUNK_LEN_W  5
`define NIC_TAG_W        5

// BAR0 byte offsets of the two huge-page slots
`define NIC_OFS_SLOT1_LO 5'h00
`define NIC_OFS_SLOT1_HI 5'h04
`define NIC_OFS_SLOT1_QW 5'h08
`define NIC_OFS_SLOT2_LO 5'h10
`define NIC_OFS_SLOT2_HI 5'h14
`define NIC_OFS_SLOT2_QW 5'h18

`endif

// ==== nic_pkg.sv ====
// NIC shared types
// TLP format codes, huge-page slot record and completer id
`default_nettype none

`include "nic_settings.svh"

package nic_pkg;

    // Fmt[1:0] and Type[4:0] of header doubleword 0
    typedef enum logic [6:0] {
        TLP_MRD32 = 7'b00_00000,
        TLP_MRD64 = 7'b01_00000,
        TLP_MWR32 = 7'b10_00000
    } tlp_fmt_type_t;

    typedef struct packed {
        logic [`NIC_ADDR_W-1:0] addr;   // Host bus address
        logic [`NIC_QW_W-1:0]   qwords; // Page length
    } page_slot_t;

    typedef struct packed {
        logic [7:0] bus;
        logic [4:0] dev;
        logic [2:0] func;
    } completer_id_t;

endpackage

`default_nettype wire

// ==== tx_page_regs.sv ====
// Huge-page slot registers
// Decodes one-doubleword BAR0 writes into the two transmit slots
`timescale 1ns/1ns
`default_nettype none

`include "nic_settings.svh"

module tx_page_regs import nic_pkg::*; (
    input  logic                   trn_clk,
    input  logic                   reset,
    input  logic [`NIC_DATA_W-1:0] trn_rd,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic [6:0]             trn_rbar_hit_n,
    output page_slot_t             slot1,
    output page_slot_t             slot2,
    output logic                   slot1_armed,
    output logic                   slot2_armed,
    input  logic                   slot1_free,
    input  logic                   slot2_free
);

    logic        in_tlp;    // Between start and end beat
    logic        beat1;     // Next beat is the second one
    logic [31:0] hdr_dw0;
    logic        hdr_bar0;
    logic        sof_beat;
    logic        eof_beat;
    logic        wr_hit;
    logic [4:0]  wr_ofs;
    logic [31:0] wr_data;

    assign sof_beat = !trn_rsrc_rdy_n && !trn_rsof_n;
    assign eof_beat = !trn_rsrc_rdy_n && !trn_reof_n;
    assign wr_ofs   = trn_rd[36:32];
    assign wr_data  = trn_rd[31:0];

    // Two-beat MWr32 of one doubleword that hit BAR0
    assign wr_hit = eof_beat && beat1 && hdr_bar0
                    && (hdr_dw0[30:24] == TLP_MWR32) && (hdr_dw0[9:0] == 10'd1);

    //----------------------------------------------------------------------
    // Beat tracking
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            in_tlp <= 1'b0;
            beat1  <= 1'b0;
        end else if (!trn_rsrc_rdy_n) begin
            in_tlp <= trn_reof_n;
            beat1  <= sof_beat && trn_reof_n;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (sof_beat) begin
            hdr_dw0  <= trn_rd[63:32];
            hdr_bar0 <= !trn_rbar_hit_n[0];
        end
    end

    //----------------------------------------------------------------------
    // Slot fields
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (wr_hit) begin
            case (wr_ofs)
                `NIC_OFS_SLOT1_LO: slot1.addr[31:0]  <= wr_data;
                `NIC_OFS_SLOT1_HI: slot1.addr[63:32] <= wr_data;
                `NIC_OFS_SLOT1_QW: slot1.qwords      <= wr_data;
                `NIC_OFS_SLOT2_LO: slot2.addr[31:0]  <= wr_data;
                `NIC_OFS_SLOT2_HI: slot2.addr[63:32] <= wr_data;
                `NIC_OFS_SLOT2_QW: slot2.qwords      <= wr_data;
                default: ;                           // Unmapped offset
            endcase
        end
    end

    // Writing the length arms a slot, a same-cycle free loses
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            slot1_armed <= 1'b0;
            slot2_armed <= 1'b0;
        end else begin
            if (wr_hit && wr_ofs == `NIC_OFS_SLOT1_QW)
                slot1_armed <= 1'b1;
            else if (slot1_free)
                slot1_armed <= 1'b0;
            if (wr_hit && wr_ofs == `NIC_OFS_SLOT2_QW)
                slot2_armed <= 1'b1;
            else if (slot2_free)
                slot2_armed <= 1'b0;
        end
    end

    a_eof_after_sof: assert property (@(posedge trn_clk) disable iff (reset)
        (eof_beat && trn_rsof_n) |-> in_tlp);

endmodule

`default_nettype wire

// ==== tx_chunk_sequencer.sv ====
// Transmit chunk sequencer
// Walks armed slots in 128-byte read chunks and raises the page interrupt
`timescale 1ns/1ns
`default_nettype none

`include "nic_settings.svh"

module tx_chunk_sequencer import nic_pkg::*; (
    input  logic                        trn_clk,
    input  logic                        reset,
    input  page_slot_t                  slot1,
    input  page_slot_t                  slot2,
    input  logic                        slot1_armed,
    input  logic                        slot2_armed,
    output logic                        slot1_free,
    output logic                        slot2_free,
    output logic                        read_chunk,
    output logic [`NIC_ADDR_W-1:0]      chunk_addr,
    output logic [`NIC_CHUNK_LEN_W-1:0] chunk_qwords,
    input  logic                        read_chunk_ack,
    output logic                        cfg_interrupt_n,
    input  logic                        cfg_interrupt_rdy_n
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_ACK,
        ST_DONE
    } state_t;

    state_t               state;
    logic                 cur_slot;     // 0 is slot 1
    logic [`NIC_QW_W-1:0] qw_left;
    logic                 cur_armed;
    logic                 last_chunk;
    logic                 page_done;
    logic [7:0]           irq_pend;     // Pages waiting for an interrupt

    assign cur_armed  = cur_slot ? slot2_armed : slot1_armed;
    assign last_chunk = (qw_left <= `NIC_QW_W'(`NIC_CHUNK_QW));

    assign read_chunk   = (state == ST_ISSUE) || (state == ST_WAIT_ACK);
    assign chunk_qwords = last_chunk ? qw_left[`NIC_CHUNK_LEN_W-1:0]
                                     : `NIC_CHUNK_LEN_W'(`NIC_CHUNK_QW);

    assign page_done  = (state == ST_DONE);
    assign slot1_free = page_done && !cur_slot;
    assign slot2_free = page_done && cur_slot;

    //----------------------------------------------------------------------
    // Slot walk
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            cur_slot <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cur_armed)
                        state <= ST_ISSUE;
                end
                ST_ISSUE, ST_WAIT_ACK: begin
                    if (read_chunk_ack)
                        state <= last_chunk ? ST_DONE : ST_ISSUE;
                    else
                        state <= ST_WAIT_ACK;
                end
                ST_DONE: begin
                    cur_slot <= !cur_slot;  // Alternate 1, 2, 1
                    state    <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Running address and remaining length
    always_ff @(posedge trn_clk) begin
        if (state == ST_IDLE && cur_armed) begin
            chunk_addr <= cur_slot ? slot2.addr : slot1.addr;
            qw_left    <= cur_slot ? slot2.qwords : slot1.qwords;
        end else if (read_chunk && read_chunk_ack) begin
            chunk_addr <= chunk_addr + `NIC_ADDR_W'(`NIC_CHUNK_QW * 8);
            qw_left    <= qw_left - `NIC_QW_W'(chunk_qwords);
        end
    end

    //----------------------------------------------------------------------
    // Legacy interrupt
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            cfg_interrupt_n <= 1'b1;
            irq_pend        <= 8'd0;
        end else if (!cfg_interrupt_n) begin
            if (!cfg_interrupt_rdy_n)
                cfg_interrupt_n <= 1'b1;            // Core took it
            irq_pend <= irq_pend + 8'(page_done);
        end else if (page_done || irq_pend != 8'd0) begin
            cfg_interrupt_n <= 1'b0;
            irq_pend        <= irq_pend + 8'(page_done) - 8'd1;
        end
    end

    // Request and its chunk stay put until the requester acks it
    a_chunk_held: assert property (@(posedge trn_clk) disable iff (reset)
        (read_chunk && !read_chunk_ack) |=>
            (read_chunk && $stable(chunk_addr) && $stable(chunk_qwords)));

endmodule

`default_nettype wire

// ==== tx_mem_rd_requester.sv ====
// Memory read requester
// Sends one 3DW or 4DW MRd TLP per chunk on the transmit local link
`timescale 1ns/1ns
`default_nettype none

`include "nic_settings.svh"

module tx_mem_rd_requester import nic_pkg::*; (
    input  logic                        trn_clk,
    input  logic                        reset,
    input  logic                        read_chunk,
    input  logic [`NIC_ADDR_W-1:0]      chunk_addr,
    input  logic [`NIC_CHUNK_LEN_W-1:0] chunk_qwords,
    output logic                        read_chunk_ack,
    input  completer_id_t               cfg_completer_id,
    input  logic                        cfg_bus_mstr_enable,
    output logic [`NIC_DATA_W-1:0]      trn_td,
    output logic [`NIC_REM_W-1:0]       trn_trem_n,
    output logic                        trn_tsof_n,
    output logic                        trn_teof_n,
    output logic                        trn_tsrc_rdy_n,
    input  logic                        trn_tdst_rdy_n,
    input  logic [3:0]                  trn_tbuf_av
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BEAT0,
        ST_BEAT1
    } state_t;

    state_t                state;
    logic [`NIC_TAG_W-1:0] tag;
    logic                  is_64;
    tlp_fmt_type_t         fmt_type;
    logic [9:0]            len_dw;
    logic [31:0]           hdr_dw0;
    logic [31:0]           hdr_dw1;
    logic [31:0]           addr_lo;

    assign is_64    = (chunk_addr[63:32] != 32'd0);
    assign fmt_type = is_64 ? TLP_MRD64 : TLP_MRD32;
    assign len_dw   = {4'd0, chunk_qwords, 1'b0};   // Two DW per QW
    assign addr_lo  = {chunk_addr[31:2], 2'b00};

    // R, Fmt/Type, R, TC, R, TD, EP, Attr, R, Length
    assign hdr_dw0 = {1'b0, fmt_type, 1'b0, 3'b000, 4'h0, 1'b0, 1'b0, 2'b00,
                      2'b00, len_dw};
    assign hdr_dw1 = {cfg_completer_id, {(8 - `NIC_TAG_W){1'b0}}, tag, 4'hF, 4'hF};

    assign read_chunk_ack = (state == ST_BEAT1) && !trn_tdst_rdy_n;

    //----------------------------------------------------------------------
    // Beat sequencing
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            tag            <= '0;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Needs bus mastering and a non-posted credit
                    if (read_chunk && cfg_bus_mstr_enable && trn_tbuf_av[0]) begin
                        trn_tsof_n     <= 1'b0;
                        trn_tsrc_rdy_n <= 1'b0;
                        state          <= ST_BEAT0;
                    end
                end
                ST_BEAT0: begin
                    if (!trn_tdst_rdy_n) begin
                        trn_tsof_n <= 1'b1;
                        trn_teof_n <= 1'b0;
                        state      <= ST_BEAT1;
                    end
                end
                ST_BEAT1: begin
                    if (!trn_tdst_rdy_n) begin
                        trn_teof_n     <= 1'b1;
                        trn_tsrc_rdy_n <= 1'b1;
                        tag            <= tag + 1'b1;  // Wraps at 32
                        state          <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Beat payload
    always_ff @(posedge trn_clk) begin
        if (state == ST_IDLE) begin
            trn_td     <= {hdr_dw0, hdr_dw1};
            trn_trem_n <= 8'h00;
        end else if (state == ST_BEAT0 && !trn_tdst_rdy_n) begin
            trn_td     <= is_64 ? chunk_addr[63:0] : {addr_lo, 32'd0};
            trn_trem_n <= is_64 ? 8'h00 : 8'h0F;
        end
    end

    a_tx_hold: assert property (@(posedge trn_clk) disable iff (reset)
        (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=>
            (!trn_tsrc_rdy_n && $stable(trn_td) && $stable(trn_trem_n)
             && $stable(trn_tsof_n) && $stable(trn_teof_n)));

endmodule

`default_nettype wire

// ==== pcie_tx_app.sv ====
// PCIe transmit application
// Host-programmed huge-page slots drive memory read requests and interrupts
`timescale 1ns/1ns
`default_nettype none

`include "nic_settings.svh"

module pcie_tx_app import nic_pkg::*; (
    input  logic                   trn_clk,
    input  logic                   reset,
    // Receive local link
    input  logic [`NIC_DATA_W-1:0] trn_rd,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic [6:0]             trn_rbar_hit_n,
    // Transmit local link
    output logic [`NIC_DATA_W-1:0] trn_td,
    output logic [`NIC_REM_W-1:0]  trn_trem_n,
    output logic                   trn_tsof_n,
    output logic                   trn_teof_n,
    output logic                   trn_tsrc_rdy_n,
    input  logic                   trn_tdst_rdy_n,
    input  logic [3:0]             trn_tbuf_av,
    // Configuration
    input  logic [15:0]            cfg_command,
    input  logic [7:0]             cfg_bus_number,
    input  logic [4:0]             cfg_device_number,
    input  logic [2:0]             cfg_function_number,
    output logic                   cfg_interrupt_n,
    input  logic                   cfg_interrupt_rdy_n
);

    page_slot_t                  slot1;
    page_slot_t                  slot2;
    logic                        slot1_armed;
    logic                        slot2_armed;
    logic                        slot1_free;
    logic                        slot2_free;
    logic                        read_chunk;
    logic                        read_chunk_ack;
    logic [`NIC_ADDR_W-1:0]      chunk_addr;
    logic [`NIC_CHUNK_LEN_W-1:0] chunk_qwords;
    completer_id_t               cfg_completer_id;
    logic                        cfg_bus_mstr_enable;

    assign cfg_completer_id    = {cfg_bus_number, cfg_device_number, cfg_function_number};
    assign cfg_bus_mstr_enable = cfg_command[2];

    //----------------------------------------------------------------------
    // Slot registers, sequencer and requester
    //----------------------------------------------------------------------
    tx_page_regs page_regs_i (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .slot1          (slot1),
        .slot2          (slot2),
        .slot1_armed    (slot1_armed),
        .slot2_armed    (slot2_armed),
        .slot1_free     (slot1_free),
        .slot2_free     (slot2_free)
    );

    tx_chunk_sequencer chunk_seq_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .slot1               (slot1),
        .slot2               (slot2),
        .slot1_armed         (slot1_armed),
        .slot2_armed         (slot2_armed),
        .slot1_free          (slot1_free),
        .slot2_free          (slot2_free),
        .read_chunk          (read_chunk),
        .chunk_addr          (chunk_addr),
        .chunk_qwords        (chunk_qwords),
        .read_chunk_ack      (read_chunk_ack),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

    tx_mem_rd_requester rd_req_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .read_chunk          (read_chunk),
        .chunk_addr          (chunk_addr),
        .chunk_qwords        (chunk_qwords),
        .read_chunk_ack      (read_chunk_ack),
        .cfg_completer_id    (cfg_completer_id),
        .cfg_bus_mstr_enable (cfg_bus_mstr_enable),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .trn_tbuf_av         (trn_tbuf_av)
    );

endmodule

`default_nettype wire

// ==== tb_tlp_model.svh ====
// Transmit request model
// Expected read chunks of each programmed page, in the order they are served
`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

logic [63:0] exp_addr[$];       // One entry per expected request
int          exp_qw[$];
bit          exp_last[$];       // Last chunk of its page
logic [4:0]  exp_tag = 5'd0;    // Next tag, wraps at 32

// Split a page into 128-byte chunks, the last one takes the remainder
function automatic void queue_page_chunks(input logic [63:0] addr, input int qwords);
    int          left;
    logic [63:0] a;
    left = qwords;
    a    = addr;
    while (left > 0) begin
        exp_addr.push_back(a);
        exp_qw.push_back((left > 16) ? 16 : left);
        exp_last.push_back(left <= 16);
        a    = a + 64'd128;
        left = left - 16;
    end
endfunction

// MRd32 for a zero upper half, else MRd64, TC 0, length in doublewords
function automatic logic [31:0] hdr_dw0_for(input logic [63:0] addr, input int qwords);
    logic [6:0] fmt_type;
    logic [9:0] len;
    fmt_type = (addr[63:32] == 32'd0) ? 7'b000_0000 : 7'b010_0000;
    len      = 10'(qwords * 2);
    return {1'b0, fmt_type, 14'd0, len};
endfunction

// Requester id, 8-bit tag field, last and first byte enables
function automatic logic [31:0] hdr_dw1_for(input logic [15:0] cpl_id, input logic [4:0] tag);
    return {cpl_id, 3'b000, tag, 4'hF, 4'hF};
endfunction

// 3DW header leaves the lower half of beat 1 empty
function automatic logic [7:0] rem_for_addr(input logic [63:0] addr);
    return (addr[63:32] == 32'd0) ? 8'h0F : 8'h00;
endfunction

`endif

// ==== tb_pcie_tx_app.sv ====
// Testbench for the PCIe transmit application
// Random slot programming, credit and back-pressure checked against a request model
`timescale 1ns/1ns
`default_nettype none

`include "nic_settings.svh"

module tb_pcie_tx_app;

    localparam int          NUM_PAGES = 16;
    localparam logic [31:0] MWR32_DW0 = 32'h4000_0001;  // MWr32, one DW
    localparam logic [31:0] MRD32_DW0 = 32'h0000_0001;  // MRd32, not a write
    localparam logic [31:0] BAR0_BASE = 32'hF7C0_0000;
    localparam logic [6:0]  HIT_BAR0  = 7'h7E;
    localparam logic [6:0]  HIT_BAR1  = 7'h7D;

    logic        trn_clk = 1'b0;
    logic        reset;
    logic [63:0] trn_rd;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy_n;
    logic [6:0]  trn_rbar_hit_n;
    logic [63:0] trn_td;
    logic [7:0]  trn_trem_n;
    logic        trn_tsof_n;
    logic        trn_teof_n;
    logic        trn_tsrc_rdy_n;
    logic        trn_tdst_rdy_n;
    logic [3:0]  trn_tbuf_av;
    logic [15:0] cfg_command;
    logic [7:0]  cfg_bus_number;
    logic [4:0]  cfg_device_number;
    logic [2:0]  cfg_function_number;
    logic        cfg_interrupt_n;
    logic        cfg_interrupt_rdy_n;

    integer      seed = 17164;
    int          errors = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          tlp_starts = 0;
    int          chunks_seen = 0;
    int          pages_seen = 0;
    int          irq_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100000;
    logic [63:0] page_addr [NUM_PAGES];
    int          page_qw [NUM_PAGES];
    logic [15:0] cpl_ids [3];

    bit          running = 1'b0;        // Out of reset, seen at a rising edge
    logic [63:0] beat0_td;
    bit          have_beat0 = 1'b0;
    logic        last_src_rdy_n = 1'b1;
    logic        last_tbuf0 = 1'b0;
    logic        last_bme = 1'b0;
    logic        last_int_n = 1'b1;
    logic        last_int_rdy_n = 1'b1;
    int          irq_delay = 0;
    bit          irq_waiting = 1'b0;

    `include "tb_tlp_model.svh"

    pcie_tx_app dut_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .trn_rd              (trn_rd),
        .trn_rsof_n          (trn_rsof_n),
        .trn_reof_n          (trn_reof_n),
        .trn_rsrc_rdy_n      (trn_rsrc_rdy_n),
        .trn_rbar_hit_n      (trn_rbar_hit_n),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .trn_tbuf_av         (trn_tbuf_av),
        .cfg_command         (cfg_command),
        .cfg_bus_number      (cfg_bus_number),
        .cfg_device_number   (cfg_device_number),
        .cfg_function_number (cfg_function_number),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

    always #2 trn_clk = ~trn_clk;   // 4 ns period

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Two-beat receive TLP, header DW0 on beat 0, address and data on beat 1
    task automatic send_rx_tlp(input logic [31:0] dw0, input logic [6:0] hit_n,
                               input logic [31:0] addr, input logic [31:0] data);
        @(negedge trn_clk);
        trn_rd         = {dw0, 32'h0000_0000};
        trn_rbar_hit_n = hit_n;
        trn_rsof_n     = 1'b0;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b0;
        @(negedge trn_clk);
        trn_rd     = {addr, data};
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b0;
        @(negedge trn_clk);
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7F;
    endtask

    task automatic write_reg(input logic [4:0] ofs, input logic [31:0] data);
        send_rx_tlp(MWR32_DW0, HIT_BAR0, BAR0_BASE | {27'd0, ofs}, data);
    endtask

    // Even pages go to slot 1, odd pages to slot 2
    task automatic program_page(input int idx);
        logic [63:0] addr;
        bit          second;
        addr   = page_addr[idx];
        second = (idx % 2) == 1;
        queue_page_chunks(addr, page_qw[idx]);
        write_reg(second ? `NIC_OFS_SLOT2_LO : `NIC_OFS_SLOT1_LO, addr[31:0]);
        write_reg(second ? `NIC_OFS_SLOT2_HI : `NIC_OFS_SLOT1_HI, addr[63:32]);
        write_reg(second ? `NIC_OFS_SLOT2_QW : `NIC_OFS_SLOT1_QW, page_qw[idx]);
    endtask

    task automatic set_completer(input int k);
        @(negedge trn_clk);
        {cfg_bus_number, cfg_device_number, cfg_function_number} = cpl_ids[k];
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - errors_before;
        tests_run++;
        if (n == 0) begin
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, n);
        end
        errors_before = errors;
    endtask

    task automatic check_request(input logic [63:0] b0, input logic [63:0] b1,
                                 input logic [7:0] rem);
        logic [63:0] addr;
        int          qw;
        bit          last;
        logic [31:0] exp_dw0;
        logic [31:0] exp_dw1;
        assert (exp_addr.size() != 0)
            else flag_error("request TLP sent with no page programmed");
        if (exp_addr.size() == 0)
            return;
        addr    = exp_addr.pop_front();
        qw      = exp_qw.pop_front();
        last    = exp_last.pop_front();
        exp_dw0 = hdr_dw0_for(addr, qw);
        exp_dw1 = hdr_dw1_for({cfg_bus_number, cfg_device_number, cfg_function_number},
                              exp_tag);
        assert (b0[63:32] == exp_dw0)
            else flag_error($sformatf("header DW0 %h, expected %h", b0[63:32], exp_dw0));
        assert (b0[31:0] == exp_dw1)
            else flag_error($sformatf("header DW1 %h, expected %h", b0[31:0], exp_dw1));
        if (addr[63:32] == 32'd0) begin
            assert (b1[63:32] == addr[31:0])
                else flag_error($sformatf("MRd32 address %h, expected %h",
                                          b1[63:32], addr[31:0]));
        end else begin
            assert (b1 == addr)
                else flag_error($sformatf("MRd64 address %h, expected %h", b1, addr));
        end
        assert (rem == rem_for_addr(addr))
            else flag_error($sformatf("trn_trem_n %h on address %h", rem, addr));
        exp_tag = exp_tag + 5'd1;
        chunks_seen++;
        if (last)
            pages_seen++;
    endtask

    //----------------------------------------------------------------------
    // Monitor, sampled at the rising edge
    //----------------------------------------------------------------------
    always @(posedge trn_clk) begin
        running = !reset;
        if (reset) begin
            have_beat0     = 1'b0;
            last_src_rdy_n = 1'b1;
            last_int_n     = 1'b1;
            last_int_rdy_n = 1'b1;
        end else begin
            if (!trn_tsrc_rdy_n && last_src_rdy_n) begin
                tlp_starts++;
                assert (last_tbuf0 && last_bme)
                    else flag_error("request started without credit or bus mastering");
            end
            if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
                if (!trn_tsof_n) begin
                    assert (trn_teof_n) else flag_error("start beat also marked as end");
                    beat0_td   = trn_td;
                    have_beat0 = 1'b1;
                end else if (!trn_teof_n) begin
                    assert (have_beat0) else flag_error("end beat without a start beat");
                    check_request(beat0_td, trn_td, trn_trem_n);
                    have_beat0 = 1'b0;
                end else begin
                    flag_error("TLP longer than two beats");
                end
            end
            if (!cfg_interrupt_n && last_int_n)
                irq_count++;
            if (cfg_interrupt_n && !last_int_n) begin
                assert (!last_int_rdy_n)
                    else flag_error("interrupt released before the core took it");
            end
            if (!last_int_n && !last_int_rdy_n) begin
                assert (cfg_interrupt_n) else flag_error("interrupt held after it was taken");
            end
            last_src_rdy_n = trn_tsrc_rdy_n;
            last_tbuf0     = trn_tbuf_av[0];
            last_bme       = cfg_command[2];
            last_int_n     = cfg_interrupt_n;
            last_int_rdy_n = cfg_interrupt_rdy_n;
        end
    end

    //----------------------------------------------------------------------
    // Random back-pressure, credit and interrupt acceptance
    //----------------------------------------------------------------------
    always @(negedge trn_clk) begin
        if (!running) begin
            trn_tdst_rdy_n      = 1'b0;
            trn_tbuf_av         = 4'hF;
            cfg_interrupt_rdy_n = 1'b1;
            irq_waiting         = 1'b0;
        end else begin
            trn_tdst_rdy_n = (({$random(seed)} % 4) == 0);             // One beat in four
            trn_tbuf_av    = {3'b111, (({$random(seed)} % 3) != 0)};
            if (!cfg_interrupt_rdy_n) begin
                cfg_interrupt_rdy_n = 1'b1;                            // One-cycle accept
            end else if (!cfg_interrupt_n) begin
                if (!irq_waiting) begin
                    irq_delay   = {$random(seed)} % 6;
                    irq_waiting = 1'b1;
                end
                if (irq_delay == 0) begin
                    cfg_interrupt_rdy_n = 1'b0;
                    irq_waiting         = 1'b0;
                end else begin
                    irq_delay = irq_delay - 1;
                end
            end
        end
    end

    // Run limit
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge trn_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        int          i;
        int          total_qw;
        logic [31:0] hi_half;
        reset               = 1'b1;
        trn_rd              = 64'd0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7F;
        trn_tdst_rdy_n      = 1'b0;
        trn_tbuf_av         = 4'hF;
        cfg_command         = 16'h0006;   // Memory space and bus master
        cfg_bus_number      = 8'd0;
        cfg_device_number   = 5'd0;
        cfg_function_number = 3'd0;
        cfg_interrupt_rdy_n = 1'b1;
        total_qw            = 0;
        for (i = 0; i < NUM_PAGES; i++) begin
            hi_half      = (({$random(seed)} % 2) == 0) ? 32'd0 : $random(seed);
            page_addr[i] = {hi_half, $random(seed) & 32'hFFFF_FFF8};
            page_qw[i]   = 1 + ({$random(seed)} % 70);
            if (i == 3)
                page_qw[i] = 32;          // Exact multiple of a chunk
            if (i == 5)
                page_qw[i] = 70;
            total_qw = total_qw + page_qw[i];
        end
        for (i = 0; i < 3; i++)
            cpl_ids[i] = $random(seed);
        cycle_limit = 1000 + NUM_PAGES * 100 + total_qw * 2;

        repeat (3) @(posedge trn_clk);
        @(negedge trn_clk);
        reset = 1'b0;

        // Wrong BAR and a read to the length register
        set_completer(0);
        send_rx_tlp(MWR32_DW0, HIT_BAR1, BAR0_BASE | 32'(`NIC_OFS_SLOT1_QW), 32'd8);
        send_rx_tlp(MRD32_DW0, HIT_BAR0, BAR0_BASE | 32'(`NIC_OFS_SLOT1_QW), 32'd8);
        repeat (30) @(negedge trn_clk);
        assert (tlp_starts == 0 && irq_count == 0)
            else flag_error("ignored receive TLP led to a request or interrupt");
        finish_test("ignored_rx");

        set_completer(1);
        cfg_command = 16'h0002;
        program_page(0);
        repeat (40) @(negedge trn_clk);
        assert (tlp_starts == 0) else flag_error("request sent with bus mastering off");
        cfg_command = 16'h0006;
        wait (pages_seen == 1);
        finish_test("bus_master_off");

        // A slot is reloaded once its previous page has been fully requested
        set_completer(2);
        for (i = 1; i < NUM_PAGES; i++) begin
            wait (pages_seen >= i - 1);
            program_page(i);
        end
        wait (pages_seen == NUM_PAGES);
        finish_test("page_walk");

        wait (irq_count == NUM_PAGES);
        wait (cfg_interrupt_n == 1'b1);
        repeat (20) @(negedge trn_clk);
        assert (irq_count == NUM_PAGES)
            else flag_error($sformatf("%0d interrupts for %0d pages", irq_count, NUM_PAGES));
        assert (exp_addr.size() == 0 && !have_beat0)
            else flag_error("expected requests left over at the end");
        finish_test("interrupts");

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d requests checked",
                 tests_run, tests_failed, errors, chunks_seen);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
nic_pkg.sv
tx_page_regs.sv
tx_chunk_sequencer.sv
tx_mem_rd_requester.sv
pcie_tx_app.sv
tb_pcie_tx_app.sv

// ==== Bender.yml ====
package:
  name: pcie_tx_app

sources:
  - include_dirs:
      - .
    files:
      - nic_pkg.sv
      - tx_page_regs.sv
      - tx_chunk_sequencer.sv
      - tx_mem_rd_requester.sv
      - pcie_tx_app.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pcie_tx_app.sv
